/* hdl/id_params.svh */
`ifndef ID_PARAMS_SVH
`define ID_PARAMS_SVH

`define ID_XLEN    32  // Data and pc width
`define ID_REG_AW  5
`define ID_REG_NUM 32

// Low two bits of every 32-bit encoding
`define ID_OPC_LEN32 2'b11

// Major opcodes, istr[6:2]
`define ID_OPC_LOAD   5'b00000
`define ID_OPC_OP_IMM 5'b00100
`define ID_OPC_AUIPC  5'b00101
`define ID_OPC_STORE  5'b01000
`define ID_OPC_OP     5'b01100
`define ID_OPC_LUI    5'b01101
`define ID_OPC_BRANCH 5'b11000
`define ID_OPC_JALR   5'b11001
`define ID_OPC_JAL    5'b11011

// funct3 for register and immediate ALU ops
`define ID_F3_ADD  3'b000
`define ID_F3_SLL  3'b001
`define ID_F3_SLT  3'b010
`define ID_F3_SLTU 3'b011
`define ID_F3_XOR  3'b100
`define ID_F3_SR   3'b101  // SRL or SRA, split by istr[30]
`define ID_F3_OR   3'b110
`define ID_F3_AND  3'b111

// funct3 for conditional branches
`define ID_F3_BEQ  3'b000
`define ID_F3_BNE  3'b001
`define ID_F3_BLT  3'b100
`define ID_F3_BGE  3'b101
`define ID_F3_BLTU 3'b110
`define ID_F3_BGEU 3'b111

// funct3 for loads and stores
`define ID_F3_B  3'b000
`define ID_F3_H  3'b001
`define ID_F3_W  3'b010
`define ID_F3_BU 3'b100
`define ID_F3_HU 3'b101

`endif

/* hdl/id_pkg.sv */
package id_pkg;

  // Instruction class from the major opcode
  typedef enum logic [3:0] {
    CLS_RA,
    CLS_IA,
    CLS_LD,
    CLS_SD,
    CLS_BR,
    CLS_JAL,
    CLS_JALR,
    CLS_LUI,
    CLS_AUIPC,
    CLS_ILLEGAL
  } istr_class_e;

  typedef enum logic [3:0] {
    ALU_NOP,
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // Compare done by execute for a taken decision
  typedef enum logic [2:0] {
    BR_FALSE,
    BR_TRUE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU
  } br_op_e;

  typedef enum logic [2:0] {
    MEM_B,
    MEM_H,
    MEM_W,
    MEM_BU,
    MEM_HU
  } mem_op_e;

endpackage

/* hdl/id_decoder.sv */
`timescale 1ns/10ps
`include "id_params.svh"

module id_decoder (
  input  logic [31:0]            istr,
  output id_pkg::istr_class_e    istr_class,
  output id_pkg::alu_op_e        alu_op,
  output id_pkg::br_op_e         br_op,
  output id_pkg::mem_op_e        mem_op,
  output logic                   is_br,
  output logic                   reg_write,
  output logic                   mem_write,
  output logic                   mem_read,
  output logic [`ID_REG_AW-1:0]  rs1,
  output logic [`ID_REG_AW-1:0]  rs2,
  output logic [`ID_REG_AW-1:0]  rd,
  output logic                   rs1_valid,
  output logic                   rs2_valid
);
  import id_pkg::*;

  logic [4:0] opcode;
  logic [2:0] funct3;
  logic       funct7_alt;  // istr[30], picks SUB and SRA
  logic       writes_rd;

  assign opcode     = istr[6:2];
  assign funct3     = istr[14:12];
  assign funct7_alt = istr[30];
  assign rs1        = istr[19:15];
  assign rs2        = istr[24:20];
  assign rd         = istr[11:7];

  // Compressed encodings fall out as illegal
  always_comb begin
    istr_class = CLS_ILLEGAL;
    if (istr[1:0] == `ID_OPC_LEN32) begin
      case (opcode)
        `ID_OPC_OP:     istr_class = CLS_RA;
        `ID_OPC_OP_IMM: istr_class = CLS_IA;
        `ID_OPC_LOAD:   istr_class = CLS_LD;
        `ID_OPC_STORE:  istr_class = CLS_SD;
        `ID_OPC_BRANCH: istr_class = CLS_BR;
        `ID_OPC_JAL:    istr_class = CLS_JAL;
        `ID_OPC_JALR:   istr_class = CLS_JALR;
        `ID_OPC_LUI:    istr_class = CLS_LUI;
        `ID_OPC_AUIPC:  istr_class = CLS_AUIPC;
        default:        istr_class = CLS_ILLEGAL;
      endcase
    end
  end

  always_comb begin
    alu_op = ALU_NOP;  // LUI too, execute passes imm through
    case (istr_class)
      CLS_RA, CLS_IA: begin
        case (funct3)
          `ID_F3_ADD:  alu_op = (istr_class == CLS_RA && funct7_alt) ? ALU_SUB : ALU_ADD;
          `ID_F3_SLL:  alu_op = ALU_SLL;
          `ID_F3_SLT:  alu_op = ALU_SLT;
          `ID_F3_SLTU: alu_op = ALU_SLTU;
          `ID_F3_XOR:  alu_op = ALU_XOR;
          `ID_F3_SR:   alu_op = funct7_alt ? ALU_SRA : ALU_SRL;
          `ID_F3_OR:   alu_op = ALU_OR;
          `ID_F3_AND:  alu_op = ALU_AND;
        endcase
      end
      // Address and link arithmetic
      CLS_LD, CLS_SD, CLS_BR, CLS_JAL, CLS_JALR, CLS_AUIPC: alu_op = ALU_ADD;
      default: alu_op = ALU_NOP;
    endcase
  end

  always_comb begin
    br_op = BR_FALSE;
    if (istr_class == CLS_JAL || istr_class == CLS_JALR) begin
      br_op = BR_TRUE;
    end else if (istr_class == CLS_BR) begin
      case (funct3)
        `ID_F3_BEQ:  br_op = BR_EQ;
        `ID_F3_BNE:  br_op = BR_NE;
        `ID_F3_BLT:  br_op = BR_LT;
        `ID_F3_BGE:  br_op = BR_GE;
        `ID_F3_BLTU: br_op = BR_LTU;
        `ID_F3_BGEU: br_op = BR_GEU;
        default:     br_op = BR_FALSE;
      endcase
    end
  end

  always_comb begin
    mem_op = MEM_W;
    if (mem_read || mem_write) begin
      case (funct3)
        `ID_F3_B:  mem_op = MEM_B;
        `ID_F3_H:  mem_op = MEM_H;
        `ID_F3_W:  mem_op = MEM_W;
        `ID_F3_BU: mem_op = MEM_BU;
        `ID_F3_HU: mem_op = MEM_HU;
        default:   mem_op = MEM_W;
      endcase
    end
  end

  // Operand usage per class
  always_comb begin
    writes_rd = 1'b0;
    rs1_valid = 1'b0;
    rs2_valid = 1'b0;
    case (istr_class)
      CLS_RA:             {writes_rd, rs1_valid, rs2_valid} = 3'b111;
      CLS_IA, CLS_LD:     {writes_rd, rs1_valid, rs2_valid} = 3'b110;
      CLS_JALR:           {writes_rd, rs1_valid, rs2_valid} = 3'b110;
      CLS_SD, CLS_BR:     {writes_rd, rs1_valid, rs2_valid} = 3'b011;
      CLS_JAL, CLS_LUI:   {writes_rd, rs1_valid, rs2_valid} = 3'b100;
      CLS_AUIPC:          {writes_rd, rs1_valid, rs2_valid} = 3'b100;
      default:            {writes_rd, rs1_valid, rs2_valid} = 3'b000;
    endcase
  end

  assign reg_write = writes_rd && (rd != '0);
  assign mem_write = (istr_class == CLS_SD);
  assign mem_read  = (istr_class == CLS_LD);
  assign is_br     = (istr_class == CLS_BR) || (istr_class == CLS_JAL) ||
                     (istr_class == CLS_JALR);

endmodule

/* hdl/id_imm_gen.sv */
`timescale 1ns/10ps
`include "id_params.svh"

module id_imm_gen (
  input  logic [31:0]          istr,
  input  id_pkg::istr_class_e  istr_class,
  output logic [`ID_XLEN-1:0]  imm
);
  import id_pkg::*;

  logic [`ID_XLEN-1:0] imm_i;
  logic [`ID_XLEN-1:0] imm_s;
  logic [`ID_XLEN-1:0] imm_b;
  logic [`ID_XLEN-1:0] imm_u;
  logic [`ID_XLEN-1:0] imm_j;

  assign imm_i = {{(`ID_XLEN-12){istr[31]}}, istr[31:20]};
  assign imm_s = {{(`ID_XLEN-12){istr[31]}}, istr[31:25], istr[11:7]};
  // Branch and jump offsets are in half words, bit 0 always zero
  assign imm_b = {{(`ID_XLEN-13){istr[31]}}, istr[31], istr[7], istr[30:25],
                  istr[11:8], 1'b0};
  assign imm_u = {istr[31:12], 12'd0};
  assign imm_j = {{(`ID_XLEN-21){istr[31]}}, istr[31], istr[19:12], istr[20],
                  istr[30:21], 1'b0};

  always_comb begin
    case (istr_class)
      CLS_IA, CLS_LD, CLS_JALR: imm = imm_i;
      CLS_SD:                   imm = imm_s;
      CLS_BR:                   imm = imm_b;
      CLS_JAL:                  imm = imm_j;
      CLS_LUI, CLS_AUIPC:       imm = imm_u;
      default:                  imm = '0;  // RA and illegal carry no immediate
    endcase
  end

endmodule

/* hdl/id_reg_file.sv */
`timescale 1ns/10ps
`include "id_params.svh"

module id_reg_file (
  input  logic                  clk,
  input  logic                  rd_en,
  input  logic [`ID_REG_AW-1:0] rs1,
  input  logic [`ID_REG_AW-1:0] rs2,
  output logic [`ID_XLEN-1:0]   rs1_data,
  output logic [`ID_XLEN-1:0]   rs2_data,
  input  logic                  wr_en,
  input  logic [`ID_REG_AW-1:0] wr_addr,
  input  logic [`ID_XLEN-1:0]   wr_data
);

  logic [`ID_XLEN-1:0] regs [0:`ID_REG_NUM-1];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (wr_en && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Same-edge write is not forwarded, the old word is returned
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rs1_data <= (rs1 == '0) ? '0 : regs[rs1];
      rs2_data <= (rs2 == '0) ? '0 : regs[rs2];
    end
  end

endmodule

/* hdl/id_hazard.sv */
`timescale 1ns/10ps
`include "id_params.svh"

module id_hazard (
  input  logic [`ID_REG_AW-1:0] rs1,
  input  logic                  rs1_valid,
  input  logic [`ID_REG_AW-1:0] rs2,
  input  logic                  rs2_valid,
  input  logic                  is_store,
  input  logic [`ID_REG_AW-1:0] de_rd,
  input  logic                  de_reg_write,
  input  logic                  de_mem_read,
  input  logic [`ID_REG_AW-1:0] em_rd,
  input  logic                  em_reg_write,
  input  logic                  em_mem_read,
  output logic                  stall
);

  logic de_load;
  logic em_load;
  logic rs1_de_hit;
  logic rs2_de_hit;
  logic em_hit;

  assign de_load = de_reg_write && de_mem_read;
  assign em_load = em_reg_write && em_mem_read;

  assign rs1_de_hit = rs1_valid && (rs1 == de_rd) && de_load;
  assign rs2_de_hit = rs2_valid && (rs2 == de_rd) && de_load;
  assign em_hit     = em_load && ((rs1_valid && (rs1 == em_rd)) ||
                                  (rs2_valid && (rs2 == em_rd)));

  // Store data from a load in de can still be forwarded later
  assign stall = rs1_de_hit || (rs2_de_hit && !is_store) || em_hit;

endmodule

/* hdl/id_stage.sv */
`timescale 1ns/10ps
`include "id_params.svh"

module id_stage (
  input  logic                  clk,
  input  logic                  rest,
  input  logic                  fd_valid,
  output logic                  fd_ready,
  input  logic [31:0]           fd_istr,
  input  logic [`ID_XLEN-1:0]   fd_pc,
  input  logic                  fd_jump,
  output logic                  de_valid,
  input  logic                  de_ready,
  output id_pkg::alu_op_e       de_alu_op,
  output id_pkg::br_op_e        de_br_op,
  output id_pkg::mem_op_e       de_mem_op,
  output logic                  de_is_br,
  output logic                  de_jump,
  output logic [`ID_XLEN-1:0]   de_pc,
  output logic [`ID_XLEN-1:0]   de_imm,
  output logic [`ID_XLEN-1:0]   de_rs1_value,
  output logic [`ID_XLEN-1:0]   de_rs2_value,
  output logic [`ID_REG_AW-1:0] de_rs1,
  output logic [`ID_REG_AW-1:0] de_rs2,
  output logic                  de_rs1_valid,
  output logic                  de_rs2_valid,
  output logic [`ID_REG_AW-1:0] de_rd,
  output logic                  de_reg_write,
  output logic                  de_mem_write,
  output logic                  de_mem_read,
  input  logic                  ex_flush_en,
  input  logic                  wb_valid,
  input  logic                  wb_reg_write,
  input  logic [`ID_REG_AW-1:0] wb_rd,
  input  logic [`ID_XLEN-1:0]   wb_reg_data,
  input  logic [`ID_REG_AW-1:0] em_rd,
  input  logic                  em_reg_write,
  input  logic                  em_mem_read
);
  import id_pkg::*;

  istr_class_e          istr_class;
  alu_op_e              alu_op;
  br_op_e               br_op;
  mem_op_e              mem_op;
  logic                 is_br;
  logic                 reg_write;
  logic                 mem_write;
  logic                 mem_read;
  logic [`ID_REG_AW-1:0] rs1;
  logic [`ID_REG_AW-1:0] rs2;
  logic [`ID_REG_AW-1:0] rd;
  logic                 rs1_valid;
  logic                 rs2_valid;
  logic [`ID_XLEN-1:0]  imm;
  logic                 load_en;
  logic                 stall;
  logic                 take;
  logic                 de_live_write;

  assign load_en       = !de_valid || de_ready;   // Stage register free or draining
  assign fd_ready      = load_en && !stall;
  assign take          = fd_valid && !stall;
  assign de_live_write = de_valid && de_reg_write; // Flushed entries produce nothing

  id_decoder id_decoder_inst (
    .istr       (fd_istr),
    .istr_class (istr_class),
    .alu_op     (alu_op),
    .br_op      (br_op),
    .mem_op     (mem_op),
    .is_br      (is_br),
    .reg_write  (reg_write),
    .mem_write  (mem_write),
    .mem_read   (mem_read),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .rs1_valid  (rs1_valid),
    .rs2_valid  (rs2_valid)
  );

  id_imm_gen id_imm_gen_inst (
    .istr       (fd_istr),
    .istr_class (istr_class),
    .imm        (imm)
  );

  // Read data lands together with the rest of the entry
  id_reg_file id_reg_file_inst (
    .clk      (clk),
    .rd_en    (load_en),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (de_rs1_value),
    .rs2_data (de_rs2_value),
    .wr_en    (wb_valid && wb_reg_write),
    .wr_addr  (wb_rd),
    .wr_data  (wb_reg_data)
  );

  id_hazard id_hazard_inst (
    .rs1          (rs1),
    .rs1_valid    (rs1_valid),
    .rs2          (rs2),
    .rs2_valid    (rs2_valid),
    .is_store     (mem_write),
    .de_rd        (de_rd),
    .de_reg_write (de_live_write),
    .de_mem_read  (de_mem_read),
    .em_rd        (em_rd),
    .em_reg_write (em_reg_write),
    .em_mem_read  (em_mem_read),
    .stall        (stall)
  );

  // Flush wins over loading, a stall or idle fetch loads a bubble
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      de_valid     <= 1'b0;
      de_alu_op    <= ALU_NOP;
      de_br_op     <= BR_FALSE;
      de_is_br     <= 1'b0;
      de_jump      <= 1'b0;
      de_reg_write <= 1'b0;
      de_mem_write <= 1'b0;
      de_mem_read  <= 1'b0;
    end else if (ex_flush_en || (load_en && !take)) begin
      de_valid     <= 1'b0;
      de_alu_op    <= ALU_NOP;
      de_br_op     <= BR_FALSE;
      de_is_br     <= 1'b0;
      de_jump      <= 1'b0;
      de_reg_write <= 1'b0;
      de_mem_write <= 1'b0;
      de_mem_read  <= 1'b0;
    end else if (load_en) begin
      de_valid     <= 1'b1;
      de_alu_op    <= alu_op;
      de_br_op     <= br_op;
      de_is_br     <= is_br;
      de_jump      <= fd_jump;
      de_reg_write <= reg_write;
      de_mem_write <= mem_write;
      de_mem_read  <= mem_read;
    end
  end

  // Payload only matters while de_valid is high
  always_ff @(posedge clk) begin
    if (load_en) begin
      de_mem_op    <= mem_op;
      de_pc        <= fd_pc;
      de_imm       <= imm;
      de_rs1       <= rs1;
      de_rs2       <= rs2;
      de_rs1_valid <= rs1_valid;
      de_rs2_valid <= rs2_valid;
      de_rd        <= rd;
    end
  end

endmodule

/* tb/id_stage_asserts.sv */
`timescale 1ns/10ps
`include "id_params.svh"

module id_stage_asserts (
  input logic                  clk,
  input logic                  rest,
  input logic                  fd_ready,
  input logic                  stall,
  input logic                  de_valid,
  input logic                  de_ready,
  input logic                  ex_flush_en,
  input id_pkg::alu_op_e       de_alu_op,
  input id_pkg::br_op_e        de_br_op,
  input logic [`ID_XLEN-1:0]   de_pc,
  input logic [`ID_XLEN-1:0]   de_imm,
  input logic [`ID_XLEN-1:0]   de_rs1_value,
  input logic [`ID_XLEN-1:0]   de_rs2_value,
  input logic [`ID_REG_AW-1:0] de_rd,
  input logic                  de_reg_write
);

  int fail_count = 0;  // Read by the testbench at the end

  // A held entry must not move until execute takes it
  assert property (@(posedge clk) disable iff (!rest)
    (de_valid && !de_ready && !ex_flush_en) |=> de_valid && $stable(de_alu_op) &&
      $stable(de_br_op) && $stable(de_pc) && $stable(de_imm) && $stable(de_rd) &&
      $stable(de_rs1_value) && $stable(de_rs2_value) && $stable(de_reg_write))
    else begin
      $error("de outputs changed while held by de_ready");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (!rest) ex_flush_en |=> !de_valid)
    else begin
      $error("de_valid still high after a flush");
      fail_count++;
    end

  // A hazard at a loading edge refuses fetch and loads a bubble
  assert property (@(posedge clk) disable iff (!rest)
    (stall && (!de_valid || de_ready)) |-> !fd_ready ##1 !de_valid)
    else begin
      $error("hazard did not hold fetch and insert a bubble");
      fail_count++;
    end

endmodule

bind id_stage id_stage_asserts id_stage_asserts_inst (
  .clk          (clk),
  .rest         (rest),
  .fd_ready     (fd_ready),
  .stall        (stall),
  .de_valid     (de_valid),
  .de_ready     (de_ready),
  .ex_flush_en  (ex_flush_en),
  .de_alu_op    (de_alu_op),
  .de_br_op     (de_br_op),
  .de_pc        (de_pc),
  .de_imm       (de_imm),
  .de_rs1_value (de_rs1_value),
  .de_rs2_value (de_rs2_value),
  .de_rd        (de_rd),
  .de_reg_write (de_reg_write)
);

/* tb/id_stage_tb.sv */
`timescale 1ns/10ps
`include "id_params.svh"

module id_stage_tb;
  import id_pkg::*;

  localparam int ACCEPT_TIMEOUT = 20;  // Cycles an instruction may wait for fd_ready
  localparam int ROWS = 12;

  typedef struct packed {
    logic [31:0]           istr;
    alu_op_e               alu;
    br_op_e                br;
    mem_op_e               mem;
    logic [`ID_XLEN-1:0]   imm;
    logic [`ID_REG_AW-1:0] rd;
    logic                  rw;
    logic                  mr;
    logic                  mw;
  } dec_row_t;

  typedef struct packed {
    logic [`ID_REG_AW-1:0] rs1;
    logic [`ID_REG_AW-1:0] rs2;
    logic                  r1v;
    logic                  r2v;
    logic                  isbr;
  } src_row_t;

  logic clk = 1'b0;
  logic rest;
  logic fd_valid, fd_ready, fd_jump;
  logic [31:0] fd_istr;
  logic [`ID_XLEN-1:0] fd_pc;
  logic de_valid, de_ready, de_is_br, de_jump;
  alu_op_e de_alu_op;
  br_op_e de_br_op;
  mem_op_e de_mem_op;
  logic [`ID_XLEN-1:0] de_pc, de_imm, de_rs1_value, de_rs2_value;
  logic [`ID_REG_AW-1:0] de_rs1, de_rs2, de_rd;
  logic de_rs1_valid, de_rs2_valid, de_reg_write, de_mem_write, de_mem_read;
  logic ex_flush_en, wb_valid, wb_reg_write;
  logic [`ID_REG_AW-1:0] wb_rd, em_rd;
  logic [`ID_XLEN-1:0] wb_reg_data;
  logic em_reg_write, em_mem_read;

  dec_row_t rows [0:ROWS-1];
  src_row_t srcs [0:ROWS-1];
  logic [`ID_XLEN-1:0] model_regs [0:2];
  logic [`ID_XLEN-1:0] held_pc;
  integer seed = 32'h033f_efb1;
  int errors = 0;
  int test_errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int stalls;
  int assert_fails;

  always #10 clk = ~clk;

  id_stage id_stage_inst (.*);

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
      errors += test_errors;
      $display("test %s: FAILED with %0d errors", name, test_errors);
    end else begin
      $display("test %s: ok", name);
    end
    test_errors = 0;
  endtask

  // Called at a falling edge, returns at the falling edge after acceptance
  task automatic issue(input logic [31:0] istr, output int waited);
    fd_valid = 1'b1;
    fd_istr  = istr;
    fd_pc    = fd_pc + 4;
    waited   = 0;
    #1;
    while (!fd_ready && waited < ACCEPT_TIMEOUT) begin
      @(negedge clk);
      #1;
      waited++;
    end
    if (!fd_ready) begin
      $display("Timeout: instruction %h was never accepted by the DUT", istr);
      $display("sim failed");
      $finish;
    end else begin
      @(posedge clk);
      @(negedge clk);
      fd_valid = 1'b0;
    end
  endtask

  task automatic wb_write(input logic [`ID_REG_AW-1:0] rd, input logic [`ID_XLEN-1:0] data);
    wb_valid     = 1'b1;
    wb_reg_write = 1'b1;
    wb_rd        = rd;
    wb_reg_data  = data;
    @(negedge clk);
    wb_valid     = 1'b0;
    wb_reg_write = 1'b0;
  endtask

  // Expected fields worked out by hand from the RV32I encodings
  task automatic fill_table();
    rows[0]  = '{32'h002081B3, ALU_ADD,  BR_FALSE, MEM_W, 32'h0,        5'd3,  1'b1, 1'b0, 1'b0};
    rows[1]  = '{32'h40208233, ALU_SUB,  BR_FALSE, MEM_W, 32'h0,        5'd4,  1'b1, 1'b0, 1'b0};
    rows[2]  = '{32'hFFF0B293, ALU_SLTU, BR_FALSE, MEM_W, 32'hFFFFFFFF, 5'd5,  1'b1, 1'b0, 1'b0};
    rows[3]  = '{32'h4030D313, ALU_SRA,  BR_FALSE, MEM_W, 32'h403,      5'd6,  1'b1, 1'b0, 1'b0};
    rows[4]  = '{32'h0080A383, ALU_ADD,  BR_FALSE, MEM_W, 32'h8,        5'd7,  1'b1, 1'b1, 1'b0};
    rows[5]  = '{32'hFE310E23, ALU_ADD,  BR_FALSE, MEM_B, 32'hFFFFFFFC, 5'd28, 1'b0, 1'b0, 1'b1};
    rows[6]  = '{32'h00209863, ALU_ADD,  BR_NE,    MEM_W, 32'h10,       5'd16, 1'b0, 1'b0, 1'b0};
    rows[7]  = '{32'hFFDFF0EF, ALU_ADD,  BR_TRUE,  MEM_W, 32'hFFFFFFFC, 5'd1,  1'b1, 1'b0, 1'b0};
    rows[8]  = '{32'h00C082E7, ALU_ADD,  BR_TRUE,  MEM_W, 32'hC,        5'd5,  1'b1, 1'b0, 1'b0};
    rows[9]  = '{32'h12345437, ALU_NOP,  BR_FALSE, MEM_W, 32'h12345000, 5'd8,  1'b1, 1'b0, 1'b0};
    rows[10] = '{32'hFFFFF497, ALU_ADD,  BR_FALSE, MEM_W, 32'hFFFFF000, 5'd9,  1'b1, 1'b0, 1'b0};
    rows[11] = '{32'h00500013, ALU_ADD,  BR_FALSE, MEM_W, 32'h5,        5'd0,  1'b0, 1'b0, 1'b0};
    // Raw source fields, their valid bits and is_br
    srcs[0]  = '{5'd1,  5'd2,  1'b1, 1'b1, 1'b0};
    srcs[1]  = '{5'd1,  5'd2,  1'b1, 1'b1, 1'b0};
    srcs[2]  = '{5'd1,  5'd31, 1'b1, 1'b0, 1'b0};
    srcs[3]  = '{5'd1,  5'd3,  1'b1, 1'b0, 1'b0};
    srcs[4]  = '{5'd1,  5'd8,  1'b1, 1'b0, 1'b0};
    srcs[5]  = '{5'd2,  5'd3,  1'b1, 1'b1, 1'b0};
    srcs[6]  = '{5'd1,  5'd2,  1'b1, 1'b1, 1'b1};
    srcs[7]  = '{5'd31, 5'd29, 1'b0, 1'b0, 1'b1};
    srcs[8]  = '{5'd1,  5'd12, 1'b1, 1'b0, 1'b1};
    srcs[9]  = '{5'd8,  5'd3,  1'b0, 1'b0, 1'b0};
    srcs[10] = '{5'd31, 5'd31, 1'b0, 1'b0, 1'b0};
    srcs[11] = '{5'd0,  5'd5,  1'b1, 1'b0, 1'b0};
  endtask

  initial begin
    rest = 1'b0;
    fd_valid = 1'b0;
    fd_istr = '0;
    fd_pc = 32'h1000;
    fd_jump = 1'b0;
    de_ready = 1'b1;
    ex_flush_en = 1'b0;
    wb_valid = 1'b0;
    wb_reg_write = 1'b0;
    wb_rd = '0;
    wb_reg_data = '0;
    em_rd = '0;
    em_reg_write = 1'b0;
    em_mem_read = 1'b0;
    fill_table();
    repeat (3) @(negedge clk);
    rest = 1'b1;

    check_val("de_valid", de_valid, 0);
    check_val("de_reg_write", de_reg_write, 0);
    check_val("de_mem_write", de_mem_write, 0);
    check_val("fd_ready", fd_ready, 1);
    end_test("reset");

    for (int i = 0; i < ROWS; i++) begin
      fd_jump = i[0];  // Predicted-jump flag just rides along
      issue(rows[i].istr, stalls);
      check_val("de_valid", de_valid, 1);
      check_val("de_alu_op", de_alu_op, rows[i].alu);
      check_val("de_br_op", de_br_op, rows[i].br);
      check_val("de_imm", de_imm, rows[i].imm);
      check_val("de_rd", de_rd, rows[i].rd);
      check_val("de_reg_write", de_reg_write, rows[i].rw);
      check_val("de_mem_read", de_mem_read, rows[i].mr);
      check_val("de_mem_write", de_mem_write, rows[i].mw);
      check_val("de_pc", de_pc, fd_pc);
      check_val("de_jump", de_jump, fd_jump);
      check_val("de_is_br", de_is_br, srcs[i].isbr);
      check_val("de_rs1", de_rs1, srcs[i].rs1);
      check_val("de_rs2", de_rs2, srcs[i].rs2);
      check_val("de_rs1_valid", de_rs1_valid, srcs[i].r1v);
      check_val("de_rs2_valid", de_rs2_valid, srcs[i].r2v);
      if (rows[i].mr || rows[i].mw) begin
        check_val("de_mem_op", de_mem_op, rows[i].mem);
      end
      end_test($sformatf("decode %h", rows[i].istr));
    end

    model_regs[0] = '0;
    for (int r = 1; r < 3; r++) begin
      model_regs[r] = $random(seed);
      wb_write(r, model_regs[r]);
    end
    wb_write(0, $random(seed));  // Must not stick in x0
    // Write strobe without wb_valid
    wb_reg_write = 1'b1;
    wb_rd        = 5'd1;
    wb_reg_data  = ~model_regs[1];
    @(negedge clk);
    wb_reg_write = 1'b0;
    issue(32'h002081B3, stalls);  // ADD x3, x1, x2
    check_val("de_rs1_value", de_rs1_value, model_regs[1]);
    check_val("de_rs2_value", de_rs2_value, model_regs[2]);
    issue(32'h002001B3, stalls);  // ADD x3, x0, x2
    check_val("de_rs1_value", de_rs1_value, model_regs[0]);
    check_val("de_rs2_value", de_rs2_value, model_regs[2]);
    end_test("register file");

    // LW x5 then ADD x6, x5, x2
    issue(32'h0000A283, stalls);
    fd_valid = 1'b1;
    fd_istr = 32'h00228333;
    #1;
    check_val("fd_ready", fd_ready, 0);
    @(negedge clk);
    check_val("de_valid", de_valid, 0);  // Bubble
    issue(32'h00228333, stalls);
    check_val("de_valid", de_valid, 1);
    check_val("de_rd", de_rd, 6);
    // SW x5, 4(x1) right behind a load of x5
    issue(32'h0000A283, stalls);
    issue(32'h0050A223, stalls);
    check_val("store stall cycles", stalls, 0);
    em_rd = 5'd5;
    em_reg_write = 1'b1;
    em_mem_read = 1'b1;
    fd_valid = 1'b1;
    fd_istr = 32'h00228333;
    #1;
    check_val("fd_ready", fd_ready, 0);
    @(negedge clk);
    check_val("de_valid", de_valid, 0);
    em_reg_write = 1'b0;
    em_mem_read = 1'b0;
    issue(32'h00228333, stalls);
    check_val("de_valid", de_valid, 1);
    end_test("load-use");

    issue(32'h002081B3, stalls);  // ADD x3, x1, x2 gets held
    held_pc = fd_pc;
    de_ready = 1'b0;
    fd_valid = 1'b1;
    fd_istr = 32'h12345437;  // LUI x8 waits behind the held entry
    fd_pc = fd_pc + 4;
    for (int k = 0; k < 3; k++) begin
      @(negedge clk);
      check_val("fd_ready", fd_ready, 0);
      check_val("de_valid", de_valid, 1);
      check_val("de_alu_op", de_alu_op, ALU_ADD);
      check_val("de_imm", de_imm, 32'h0);
      check_val("de_pc", de_pc, held_pc);
      check_val("de_rd", de_rd, 3);
      check_val("de_rs1_value", de_rs1_value, model_regs[1]);
      check_val("de_rs2_value", de_rs2_value, model_regs[2]);
    end
    de_ready = 1'b1;
    issue(32'h12345437, stalls);
    check_val("de_rd", de_rd, 8);
    check_val("de_imm", de_imm, 32'h12345000);
    end_test("back-pressure");

    issue(32'h002081B3, stalls);
    de_ready = 1'b0;
    ex_flush_en = 1'b1;
    @(negedge clk);
    check_val("de_valid", de_valid, 0);
    ex_flush_en = 1'b0;
    de_ready = 1'b1;
    end_test("flush");

    assert_fails = id_stage_inst.id_stage_asserts_inst.fail_count;
    $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
             tests_run, tests_failed, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+hdl
hdl/id_pkg.sv
hdl/id_decoder.sv
hdl/id_imm_gen.sv
hdl/id_reg_file.sv
hdl/id_hazard.sv
hdl/id_stage.sv
tb/id_stage_asserts.sv
tb/id_stage_tb.sv
